// File: ddr_test.f
hw/ddr_test_pkg.sv
hw/mem_port_if.sv
hw/uart_phy.sv
hw/cmd_engine.sv
hw/mem_port_model.sv
hw/seg_hex595.sv
hw/ddr_test_top.sv
sim/tb_ddr_test_top.sv

// File: hw/cmd_engine.sv
`timescale 1ns/1ps

module cmd_engine import ddr_test_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  mem_port_if.master  mem,
  input  logic [7:0]  rx_data,
  input  logic        rx_valid,
  output logic [7:0]  tx_data,
  output logic        tx_start,
  input  logic        tx_busy,
  output logic [31:0] show_word,
  output logic [7:0]  debug8
);

  localparam logic [2:0] S_OP      = 3'd0;  // wait for opcode
  localparam logic [2:0] S_ADDR    = 3'd1;
  localparam logic [2:0] S_DATA    = 3'd2;
  localparam logic [2:0] S_CALIB   = 3'd3;  // hold until controller is ready
  localparam logic [2:0] S_WR_CMD  = 3'd4;
  localparam logic [2:0] S_RD_WAIT = 3'd5;
  localparam logic [2:0] S_RD_TAKE = 3'd6;
  localparam logic [2:0] S_REPLY   = 3'd7;

  logic [2:0]  state;
  logic [7:0]  op;
  logic [1:0]  byte_cnt;
  mem_addr_u   addr;
  logic [31:0] word;       // write data from the host
  logic [31:0] tx_buf;     // reply bytes, msb first
  logic [2:0]  tx_left;
  logic [6:0]  frame_cnt;  // wraps at 128

  assign mem.cmd_addr = addr;
  assign mem.wr_data  = word;
  assign debug8       = {mem.calib_done, frame_cnt};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_OP;
      byte_cnt   <= '0;
      tx_left    <= '0;
      frame_cnt  <= '0;
      show_word  <= '0;
      tx_start   <= 1'b0;
      mem.cmd_en <= 1'b0;
      mem.cmd_rw <= 1'b0;
      mem.wr_en  <= 1'b0;
      mem.rd_en  <= 1'b0;
    end else begin
      // strobes are single cycle
      mem.cmd_en <= 1'b0;
      mem.wr_en  <= 1'b0;
      mem.rd_en  <= 1'b0;
      tx_start   <= 1'b0;
      case (state)
        S_OP: if (rx_valid) begin
          op       <= rx_data;
          byte_cnt <= '0;
          if (rx_data == op_write || rx_data == op_read) begin
            state <= S_ADDR;
          end else begin
            tx_buf  <= {rsp_err, 24'h0};  // bad opcode, answer now
            tx_left <= 3'd1;
            state   <= S_REPLY;
          end
        end
        S_ADDR: if (rx_valid) begin
          addr.flat <= {addr.flat[15:0], rx_data};
          byte_cnt  <= byte_cnt + 1'b1;
          if (byte_cnt == 2'(ADDR_BYTES - 1)) begin
            byte_cnt <= '0;
            state    <= (op == op_write) ? S_DATA : S_CALIB;
          end
        end
        S_DATA: if (rx_valid) begin
          word     <= {word[23:0], rx_data};
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == 2'(DATA_BYTES - 1)) state <= S_CALIB;
        end
        S_CALIB: if (mem.calib_done) begin
          if (op == op_write) begin
            mem.wr_en <= 1'b1;  // data goes ahead of the command
            state     <= S_WR_CMD;
          end else begin
            mem.cmd_en <= 1'b1;
            mem.cmd_rw <= 1'b1;
            state      <= S_RD_WAIT;
          end
        end
        S_WR_CMD: begin
          mem.cmd_en <= 1'b1;
          mem.cmd_rw <= 1'b0;
          tx_buf     <= {rsp_ack, 24'h0};
          tx_left    <= 3'd1;
          frame_cnt  <= frame_cnt + 1'b1;
          state      <= S_REPLY;
        end
        S_RD_WAIT: if (!mem.rd_empty) begin
          mem.rd_en <= 1'b1;
          state     <= S_RD_TAKE;
        end
        S_RD_TAKE: begin  // rd_en high this cycle
          show_word <= mem.rd_data;
          tx_buf    <= mem.rd_data;
          tx_left   <= 3'(DATA_BYTES);
          frame_cnt <= frame_cnt + 1'b1;
          state     <= S_REPLY;
        end
        default: if (!tx_busy && !tx_start) begin
          // tx_busy lags tx_start by a cycle
          if (tx_left != 3'd0) begin
            tx_data  <= tx_buf[31:24];
            tx_buf   <= {tx_buf[23:0], 8'h00};
            tx_left  <= tx_left - 1'b1;
            tx_start <= 1'b1;
          end else begin
            state <= S_OP;  // last stop bit done
          end
        end
      endcase
    end
  end

endmodule

// File: hw/ddr_test_pkg.sv
package ddr_test_pkg;

  //////////////////////////////////////////////////
  // address word, one flat value or its dram fields
  //////////////////////////////////////////////////

  typedef union packed {
    logic [23:0] flat;        // as sent by host, msb first
    struct packed {
      logic [12:0] row;       // not decoded by the model
      logic [2:0]  bank;
      logic [5:0]  col;
      logic [1:0]  byte_sel;  // byte lane within the word
    } fields;                 // row-bank-column order
  } mem_addr_u;

  //////////////////////////////////////////////////
  // frame bytes
  //////////////////////////////////////////////////

  localparam logic [7:0] op_write = 8'h57;  // 'W'
  localparam logic [7:0] op_read  = 8'h52;  // 'R'

  localparam logic [7:0] rsp_ack  = 8'h4b;  // 'K'
  localparam logic [7:0] rsp_err  = 8'h45;  // 'E'

  // frame layout
  localparam int ADDR_BYTES = 3;
  localparam int DATA_BYTES = 4;

endpackage

// File: hw/ddr_test_top.sv
`timescale 1ns/1ps

module ddr_test_top #(
  parameter int CLKS_PER_BIT = 434,   // 50 MHz / 115200
  parameter int CALIB_CYCLES = 1000,
  parameter int RD_LATENCY   = 8,
  parameter int SEG_DIV      = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       uart_rxd,
  output logic       uart_txd,
  output logic [7:0] debug8,
  output logic       seg_clk,
  output logic       seg_dat,
  output logic       seg_str
);

  logic [7:0]  rx_data;
  logic        rx_valid;
  logic [7:0]  tx_data;
  logic        tx_start;
  logic        tx_busy;
  logic [31:0] show_word;  // last word read back

  mem_port_if mem_bus ();

  uart_phy #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_phy_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rxd      (uart_rxd),
    .txd      (uart_txd),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
  );

  cmd_engine cmd_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem       (mem_bus.master),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .tx_data   (tx_data),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .show_word (show_word),
    .debug8    (debug8)
  );

  // stands in for the ddr3 controller user port
  mem_port_model #(
    .CALIB_CYCLES (CALIB_CYCLES),
    .RD_LATENCY   (RD_LATENCY)
  ) mem_port_model_i (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.slave)
  );

  seg_hex595 #(.SEG_DIV(SEG_DIV)) seg_hex595_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .show_word (show_word),
    .seg_clk   (seg_clk),
    .seg_dat   (seg_dat),
    .seg_str   (seg_str)
  );

endmodule

// File: hw/mem_port_if.sv
`timescale 1ns/1ps

// user side of the memory controller, one command port
interface mem_port_if import ddr_test_pkg::*; ();

  // command channel
  logic        cmd_en;
  logic        cmd_rw;      // 1 = read
  mem_addr_u   cmd_addr;

  // write data channel
  logic        wr_en;
  logic [31:0] wr_data;

  // read return channel
  logic        rd_en;
  logic [31:0] rd_data;
  logic        rd_empty;

  logic        calib_done;  // no commands before this

  modport master (
    output cmd_en, cmd_rw, cmd_addr, wr_en, wr_data, rd_en,
    input  rd_data, rd_empty, calib_done
  );

  modport slave (
    input  cmd_en, cmd_rw, cmd_addr, wr_en, wr_data, rd_en,
    output rd_data, rd_empty, calib_done
  );

endinterface

// File: hw/mem_port_model.sv
`timescale 1ns/1ps

module mem_port_model #(
  parameter int CALIB_CYCLES = 1000,
  parameter int RD_LATENCY   = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  mem_port_if.slave  mem
);

  localparam int KW = $clog2(CALIB_CYCLES);
  localparam int LW = $clog2(RD_LATENCY + 1);

  logic [31:0]   mem_q [0:511];
  logic [511:0]  vld;      // word written since reset
  logic [31:0]   wr_hold;  // one-deep write data fifo
  logic [8:0]    cmd_idx;
  logic [8:0]    rd_idx;
  logic [KW-1:0] calib_cnt;
  logic [LW-1:0] rd_cnt;
  logic          rd_busy;
  logic          rd_fire;

  // bank and column select the word, row and byte alias
  assign cmd_idx = {mem.cmd_addr.fields.bank, mem.cmd_addr.fields.col};
  assign rd_fire = rd_busy && (rd_cnt == '0);

  //////////////////////////////////////////////////
  // calibration and read queue control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      calib_cnt      <= '0;
      mem.calib_done <= 1'b0;
      rd_busy        <= 1'b0;
      rd_cnt         <= '0;
      mem.rd_empty   <= 1'b1;
      vld            <= '0;  // reads as zero until written
    end else begin
      if (!mem.calib_done) begin
        if (calib_cnt == KW'(CALIB_CYCLES - 1)) mem.calib_done <= 1'b1;
        else calib_cnt <= calib_cnt + 1'b1;
      end
      if (mem.cmd_en && !mem.cmd_rw) vld[cmd_idx] <= 1'b1;
      if (mem.cmd_en && mem.cmd_rw) begin
        rd_busy <= 1'b1;
        rd_cnt  <= LW'(RD_LATENCY - 1);
      end else if (rd_fire) begin
        rd_busy      <= 1'b0;
        mem.rd_empty <= 1'b0;  // word ready
      end else if (rd_busy) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
      if (mem.rd_en) mem.rd_empty <= 1'b1;  // popped
    end
  end

  // storage and data path
  always_ff @(posedge clk) begin
    if (mem.wr_en) wr_hold <= mem.wr_data;
    if (mem.cmd_en && !mem.cmd_rw) mem_q[cmd_idx] <= wr_hold;
    if (mem.cmd_en && mem.cmd_rw) rd_idx <= cmd_idx;
    if (rd_fire) mem.rd_data <= vld[rd_idx] ? mem_q[rd_idx] : 32'h0;
  end

endmodule

// File: hw/seg_hex595.sv
`timescale 1ns/1ps

module seg_hex595 #(
  parameter int SEG_DIV = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] show_word,
  output logic        seg_clk,
  output logic        seg_dat,
  output logic        seg_str
);

  localparam int DW = $clog2(SEG_DIV);

  logic [DW-1:0] div_cnt;
  logic [5:0]    bit_idx;     // 32 is the strobe slot
  logic [31:0]   frame_sr;
  logic [31:0]   next_frame;

  // active low, {dp, g..a}, dp kept dark
  function automatic logic [7:0] seg_enc(input logic [3:0] nib);
    case (nib)
      4'h0: seg_enc = 8'hc0;
      4'h1: seg_enc = 8'hf9;
      4'h2: seg_enc = 8'ha4;
      4'h3: seg_enc = 8'hb0;
      4'h4: seg_enc = 8'h99;
      4'h5: seg_enc = 8'h92;
      4'h6: seg_enc = 8'h82;
      4'h7: seg_enc = 8'hf8;
      4'h8: seg_enc = 8'h80;
      4'h9: seg_enc = 8'h90;
      4'ha: seg_enc = 8'h88;
      4'hb: seg_enc = 8'h83;  // lower case b
      4'hc: seg_enc = 8'hc6;
      4'hd: seg_enc = 8'ha1;  // lower case d
      4'he: seg_enc = 8'h86;
      default: seg_enc = 8'h8e;
    endcase
  endfunction

  // digit 3 leaves first
  assign next_frame = {seg_enc(show_word[15:12]), seg_enc(show_word[11:8]),
                       seg_enc(show_word[7:4]), seg_enc(show_word[3:0])};

  //////////////////////////////////////////////////
  // shift engine, one bit per SEG_DIV clocks
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      bit_idx <= 6'd32;  // start with a fresh frame
      seg_clk <= 1'b0;
      seg_dat <= 1'b0;
      seg_str <= 1'b0;
    end else begin
      div_cnt <= (div_cnt == DW'(SEG_DIV - 1)) ? '0 : div_cnt + 1'b1;
      // rising edge mid-period, data settled
      seg_clk <= (bit_idx != 6'd32) && (div_cnt >= DW'(SEG_DIV / 2));
      if (div_cnt == '0) begin
        if (bit_idx == 6'd32) begin
          seg_str  <= 1'b0;
          seg_dat  <= next_frame[31];  // word captured here
          frame_sr <= {next_frame[30:0], 1'b0};
          bit_idx  <= '0;
        end else if (bit_idx == 6'd31) begin
          seg_str <= 1'b1;  // latch the chain
          bit_idx <= 6'd32;
        end else begin
          seg_dat  <= frame_sr[31];
          frame_sr <= {frame_sr[30:0], 1'b0};
          bit_idx  <= bit_idx + 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/uart_phy.sv
`timescale 1ns/1ps

module uart_phy #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic       txd,
  output logic [7:0] rx_data,
  output logic       rx_valid,
  input  logic [7:0] tx_data,
  input  logic       tx_start,
  output logic       tx_busy
);

  localparam int CW = $clog2(CLKS_PER_BIT);

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  logic [1:0]    rxd_sync;   // [1] is the clean copy
  logic [1:0]    rx_st;
  logic [CW-1:0] rx_cnt;
  logic [2:0]    rx_bit;
  logic [7:0]    rx_shift;
  logic [CW-1:0] tx_cnt;
  logic [3:0]    tx_bit;     // start, 8 data, stop
  logic [9:0]    tx_shift;

  assign rx_data = rx_shift;  // qualified by rx_valid
  assign txd     = tx_shift[0];

  //////////////////////////////////////////////////
  // receiver
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_sync <= 2'b11;  // line idles high
      rx_st    <= RX_IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rx_valid <= 1'b0;
      rx_cnt   <= rx_cnt + 1'b1;
      case (rx_st)
        RX_IDLE: begin
          rx_cnt <= '0;
          if (!rxd_sync[1]) rx_st <= RX_START;  // falling edge
        end
        RX_START: if (rx_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
          rx_cnt <= '0;
          rx_bit <= '0;
          rx_st  <= rxd_sync[1] ? RX_IDLE : RX_DATA;  // glitch, not a start bit
        end
        RX_DATA: if (rx_cnt == CW'(CLKS_PER_BIT - 1)) begin
          rx_cnt   <= '0;
          rx_shift <= {rxd_sync[1], rx_shift[7:1]};  // lsb first
          rx_bit   <= rx_bit + 1'b1;
          if (rx_bit == 3'd7) rx_st <= RX_STOP;
        end
        default: if (rx_cnt == CW'(CLKS_PER_BIT - 1)) begin
          rx_valid <= rxd_sync[1];  // framing error drops the byte
          rx_st    <= RX_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // transmitter
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_shift <= 10'h3ff;
      tx_busy  <= 1'b0;
      tx_cnt   <= '0;
      tx_bit   <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_shift <= {1'b1, tx_data, 1'b0};  // stop, data, start
        tx_busy  <= 1'b1;
        tx_cnt   <= '0;
        tx_bit   <= '0;
      end
    end else if (tx_cnt == CW'(CLKS_PER_BIT - 1)) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};  // refill with idle level
      tx_bit   <= tx_bit + 1'b1;
      if (tx_bit == 4'd9) tx_busy <= 1'b0;  // end of stop bit
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

endmodule

// File: sim/tb_ddr_test_top.sv
`timescale 1ns/1ps

module tb_ddr_test_top;

  localparam int BIT_CLKS   = 16;    // fast uart for sim
  localparam int CALIB_CLKS = 64;
  localparam int SEG_CLKS   = 8;
  localparam int FIRST_LIMIT = 6000;  // whole frame plus latency
  localparam logic [7:0] OP_W  = 8'h57;
  localparam logic [7:0] OP_R  = 8'h52;
  localparam logic [7:0] RSP_K = 8'h4b;
  localparam int SEL_TXD = 0;
  localparam int SEL_SCK = 1;
  localparam int SEL_STR = 2;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        uart_rxd;
  logic        uart_txd;
  logic [7:0]  debug8;
  logic        seg_clk;
  logic        seg_dat;
  logic        seg_str;

  logic [31:0] ref_mem [0:511];  // keyed by {bank, col}
  logic [31:0] rng;
  int          frame_total;      // W and R frames

  ddr_test_top #(
    .CLKS_PER_BIT (BIT_CLKS),
    .CALIB_CYCLES (CALIB_CLKS),
    .RD_LATENCY   (8),
    .SEG_DIV      (SEG_CLKS)
  ) ddr_test_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .uart_rxd (uart_rxd),
    .uart_txd (uart_txd),
    .debug8   (debug8),
    .seg_clk  (seg_clk),
    .seg_dat  (seg_dat),
    .seg_str  (seg_str)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // reference helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // standard glyphs, active low on the wire, dot dark
  function automatic logic [7:0] seg_glyph(input logic [3:0] d);
    logic [6:0] lit;  // gfedcba, 1 = lit
    case (d)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    seg_glyph = ~{1'b0, lit};
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      SEL_TXD: probe = uart_txd;
      SEL_SCK: probe = seg_clk;
      default: probe = seg_str;
    endcase
  endfunction

  task abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
    abort_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, sig, exp, got));
  endtask

  // polls a dut output at negedge, stable there
  task wait_for_level(input int sel, input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level) begin
      n = n + 1;
      if (n > limit) abort_run({"timeout waiting for ", what});
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // uart host side
  //////////////////////////////////////////////////

  task send_byte(input logic [7:0] b);
    logic [9:0] bits;
    int i;
    bits = {1'b1, b, 1'b0};  // stop, data, start
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rxd <= bits[i];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
  endtask

  task recv_byte(input int limit, output logic [7:0] b);
    int i;
    wait_for_level(SEL_TXD, 1'b0, limit, "a reply start bit on uart_txd");
    repeat (BIT_CLKS / 2) @(negedge clk);  // mid start bit
    assert (uart_txd === 1'b0) else abort_run("start bit on uart_txd ended early");
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = uart_txd;  // lsb first
    end
    repeat (BIT_CLKS) @(negedge clk);
    assert (uart_txd === 1'b1) else abort_run("stop bit missing on uart_txd");
  endtask

  // next whole 595 frame, strobe to strobe
  task check_display(input logic [15:0] val);
    logic [31:0] exp_frame;
    logic [31:0] got_frame;
    int k;
    exp_frame = {seg_glyph(val[15:12]), seg_glyph(val[11:8]),
                 seg_glyph(val[7:4]), seg_glyph(val[3:0])};
    got_frame = '0;
    wait_for_level(SEL_STR, 1'b1, 40 * SEG_CLKS, "seg_str before a display frame");
    wait_for_level(SEL_STR, 1'b0, 4 * SEG_CLKS, "start of a display frame");
    for (k = 0; k < 32; k++) begin
      wait_for_level(SEL_SCK, 1'b1, 4 * SEG_CLKS, "a rising seg_clk");
      got_frame = {got_frame[30:0], seg_dat};  // digit 3 msb first
      wait_for_level(SEL_SCK, 1'b0, 4 * SEG_CLKS, "a falling seg_clk");
    end
    wait_for_level(SEL_STR, 1'b1, 4 * SEG_CLKS, "seg_str closing the frame");
    assert (got_frame === exp_frame) else report_mismatch("seg_dat", exp_frame, got_frame);
  endtask

  // one frame out, reply checked while it is still being sent
  task run_frame(input int nbytes, input logic [7:0] op, input logic [23:0] addr,
                 input logic [31:0] data, input int nrsp, input logic [31:0] rsp);
    logic [7:0] frame_bytes [0:7];
    logic [7:0] got;
    logic [7:0] exp;
    int i;
    int j;
    frame_bytes[0] = op;
    for (i = 0; i < 3; i++) frame_bytes[1 + i] = addr[23 - 8 * i -: 8];
    for (i = 0; i < 4; i++) frame_bytes[4 + i] = data[31 - 8 * i -: 8];
    fork
      for (i = 0; i < nbytes; i++) send_byte(frame_bytes[i]);
      for (j = 0; j < nrsp; j++) begin
        recv_byte((j == 0) ? FIRST_LIMIT : 4 * BIT_CLKS, got);
        exp = rsp[8 * (nrsp - 1 - j) +: 8];
        assert (got === exp) else report_mismatch("uart_txd", exp, got);
      end
    join
    repeat (BIT_CLKS) @(posedge clk);  // tail of the last stop bit
    if (op == OP_R) check_display(rsp[15:0]);
    if (op == OP_W || op == OP_R) frame_total = frame_total + 1;
    if (op == OP_W) ref_mem[addr[10:2]] = data;  // bank and column
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int fd;
    int fields;
    int k;
    logic [8*160-1:0] text_line;
    logic [31:0] f_nb, f_op, f_addr, f_data, f_nrsp, f_rsp;
    logic [23:0] r_addr;
    logic [23:0] alias_addr;
    logic [31:0] r_data;

    rst_n       = 1'b0;
    uart_rxd    = 1'b1;  // line idle
    frame_total = 0;
    rng         = 32'h8e96_516b;
    for (k = 0; k < 512; k++) ref_mem[k] = '0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // first frame goes out next, so calib is still low here
    assert (uart_txd === 1'b1) else report_mismatch("uart_txd", 1, uart_txd);
    assert (debug8 === 8'h00) else report_mismatch("debug8", 0, debug8);

    fd = $fopen("sim/test_input.txt", "r");
    if (fd == 0) abort_run("cannot open sim/test_input.txt");
    while (!$feof(fd)) begin
      text_line = '0;
      if ($fgets(text_line, fd) > 0) begin
        fields = $sscanf(text_line, "%h %h %h %h %h %h",
                         f_nb, f_op, f_addr, f_data, f_nrsp, f_rsp);
        if (fields == 6) run_frame(f_nb, f_op[7:0], f_addr[23:0], f_data, f_nrsp, f_rsp);
      end
    end
    $fclose(fd);
    assert (frame_total > 0) else abort_run("no transactions found in sim/test_input.txt");

    // random pairs, read back through an alias of the written word
    for (k = 0; k < 8; k++) begin
      rng    = lcg_next(rng);
      r_addr = rng[23:0];
      rng    = lcg_next(rng);
      r_data = rng;
      run_frame(8, OP_W, r_addr, r_data, 1, RSP_K);
      rng        = lcg_next(rng);
      alias_addr = {rng[31:19], r_addr[10:2], rng[1:0]};  // new row and byte
      run_frame(4, OP_R, alias_addr, 32'h0, 4, ref_mem[alias_addr[10:2]]);
    end

    @(negedge clk);
    assert (debug8 === {1'b1, frame_total[6:0]})
      else report_mismatch("debug8", {1'b1, frame_total[6:0]}, debug8);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: sim/test_input.txt
# columns: nbytes op addr data nrsp reply, all hex
# nbytes = frame bytes sent (op, 3 addr, 4 data), reply = nrsp bytes msb first
8 57 000104 deadbeef 1 4b
4 52 000104 00000000 4 deadbeef
8 57 1234f8 cafe0123 1 4b
4 52 1234f8 00000000 4 cafe0123
8 57 00ff7c 0badf00d 1 4b
4 52 00ff7c 00000000 4 0badf00d
4 52 000104 00000000 4 deadbeef
8 57 abc208 13572468 1 4b
4 52 00020b 00000000 4 13572468
8 57 000310 89abcdef 1 4b
4 52 000313 00000000 4 89abcdef
4 52 000600 00000000 4 00000000
1 58 000000 00000000 1 45
4 52 000104 00000000 4 deadbeef
1 3f 000000 00000000 1 45
4 52 000600 00000000 4 00000000
